// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mdu_tb
FILELIST  ?= mdu_top.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

// File: mdu_top.f
rtl/mdu_pkg.sv
rtl/mdu_iter_counter.sv
rtl/mdu_ctrl_fsm.sv
rtl/mdu_datapath.sv
rtl/mdu_top.sv
tb/tb_clk_gen.sv
tb/mdu_tb.sv

// File: rtl/mdu_ctrl_fsm.sv
// MDU control FSM, sequences IDLE, ITER and CORR and forms ready and the step enables
`timescale 1ns/1ps

module mdu_ctrl_fsm import mdu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_vd_i,     // Command valid level
    input  mdu_op_e     op_i,
    input  mdu_status_s status_i,
    input  logic        cnt_last_i,
    output mdu_state_e  state_o,
    output logic        step_en_o,    // Datapath registers advance
    output logic        cnt_load_o,
    output logic        cnt_shift_o,
    output logic        res_rdy_o
);

mdu_state_e state_ff;
mdu_state_e state_next;
logic       iter_req;   // Start the iterative path
logic       corr_need;  // Divide class only
logic       rdy;        // Ready before the valid gate

assign iter_req  = cmd_vd_i & (state_ff == MDU_IDLE) & status_i.ops_non_zero;
assign corr_need = op_i[2] & status_i.corr_req;

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        state_ff <= MDU_IDLE;
    end else begin
        state_ff <= state_next;
    end
end

always_comb begin
    state_next = MDU_IDLE;  // Dropped valid aborts to IDLE
    if (cmd_vd_i) begin
        case (state_ff)
            MDU_IDLE: state_next = iter_req ? MDU_ITER : MDU_IDLE;
            MDU_ITER: state_next = ~cnt_last_i ? MDU_ITER
                                 : corr_need   ? MDU_CORR
                                               : MDU_IDLE;
            default:  state_next = MDU_IDLE;  // CORR lasts one cycle
        endcase
    end
end

always_comb begin
    case (state_ff)
        MDU_IDLE: rdy = ~iter_req;                // Zero operand shortcut
        MDU_ITER: rdy = cnt_last_i & ~corr_need;
        MDU_CORR: rdy = 1'b1;
        default:  rdy = 1'b0;
    endcase
end

assign res_rdy_o   = cmd_vd_i & rdy;
assign step_en_o   = cmd_vd_i & ~res_rdy_o;
assign cnt_load_o  = iter_req;
assign cnt_shift_o = (state_ff == MDU_ITER);
assign state_o     = state_ff;

// --------------------
// Checks
// --------------------

fsm_xcheck : assert property (
    @(posedge clk) disable iff (~rst_n)
    !$isunknown({cmd_vd_i, state_ff})
) else $error("MDU FSM: unknown state or valid");

fsm_idle_jump : assert property (
    @(posedge clk) disable iff (~rst_n)
    (state_ff == MDU_IDLE) & ~iter_req |=> (state_ff == MDU_IDLE)
) else $error("MDU FSM: left IDLE without a request");

fsm_iter_hold : assert property (
    @(posedge clk) disable iff (~rst_n)
    (state_ff == MDU_ITER) & cmd_vd_i & ~cnt_last_i |=> (state_ff == MDU_ITER)
) else $error("MDU FSM: left ITER before the last step");

fsm_iter_to_corr : assert property (
    @(posedge clk) disable iff (~rst_n)
    (state_ff == MDU_ITER) & cmd_vd_i & cnt_last_i
        |=> ((state_ff == MDU_CORR) == $past(corr_need))
) else $error("MDU FSM: CORR entry does not match the correction request");

fsm_corr_to_idle : assert property (
    @(posedge clk) disable iff (~rst_n)
    (state_ff == MDU_CORR) |=> (state_ff == MDU_IDLE)
) else $error("MDU FSM: stayed out of IDLE after CORR");

endmodule

// File: rtl/mdu_datapath.sv
// MDU datapath, radix-2 multiply and non-restoring divide steps on one shared adder
`timescale 1ns/1ps

module mdu_datapath import mdu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  mdu_req_s    req_i,
    input  mdu_state_e  state_i,
    input  logic        step_en_i,  // Registers take the next step
    output mdu_status_s status_o,
    output mdu_word_t   res_o
);

// Decode
logic              is_div;
logic              st_idle;
logic              st_corr;
logic              mul_hi;        // High product wanted
logic              mul_op1_sgn;   // Multiplicand is signed
logic              mul_op2_sgn;   // Multiplier is signed
logic              mul_op1_neg;
logic              div_sgn;       // DIV or REM
logic              div_op1_neg;
logic              div_op2_neg;
logic              div_is_div;    // Signed quotient
logic              div_is_rem;
logic              ops_diff_sgn;
// Multiply step
logic              mul_bit;       // Current multiplier bit
logic              mul_prev;      // Previous multiplier bit
logic              mul_add;
logic              mul_neg;
mdu_word_t         mul_res_hi;
mdu_word_t         mul_res_lo;
// Divide step
logic              div_step_sgn;
logic              div_inv;
logic              div_rem_c;
mdu_word_t         div_rem;
logic              div_quo_bit;
mdu_word_t         div_quo;
// Shared adder, one bit wider than a word
logic              sum_sub;
logic [MDU_XLEN:0] sum_op1;
logic [MDU_XLEN:0] sum_op2;
logic [MDU_XLEN:0] sum_res;
// Intermediate registers
logic              c_ff;
logic              c_next;
mdu_word_t         hi_ff;
mdu_word_t         hi_next;
mdu_word_t         lo_ff;
mdu_word_t         lo_next;
mdu_word_t         dvdnd_lo_ff;
mdu_word_t         dvdnd_lo_next;

assign is_div       = req_i.op[2];
assign st_idle      = (state_i == MDU_IDLE);
assign st_corr      = (state_i == MDU_CORR);
assign mul_hi       = |req_i.op[1:0];
assign mul_op1_sgn  = ~&req_i.op[1:0];  // All but MULHU
assign mul_op2_sgn  = ~req_i.op[1];     // MUL and MULH
assign mul_op1_neg  = mul_op1_sgn & req_i.op1[MDU_XLEN-1];
assign div_sgn      = ~req_i.op[0];
assign div_op1_neg  = div_sgn & req_i.op1[MDU_XLEN-1];
assign div_op2_neg  = div_sgn & req_i.op2[MDU_XLEN-1];
assign div_is_div   = (req_i.op[1:0] == 2'b00);
assign div_is_rem   = req_i.op[1];
assign ops_diff_sgn = req_i.op1[MDU_XLEN-1] ^ req_i.op2[MDU_XLEN-1];

// --------------------
// Multiply step
// --------------------

// Signed multiplier uses the Booth digit b(k-1) - b(k), so the MSB weighs negative
assign mul_bit  = st_idle ? req_i.op2[0] : lo_ff[0];
assign mul_prev = st_idle ? 1'b0 : c_ff;
assign mul_neg  = mul_op2_sgn & mul_bit & ~mul_prev;           // Digit -1
assign mul_add  = mul_op2_sgn ? (mul_bit ^ mul_prev) : mul_bit;  // Digit non-zero

// Sum LSB drops into the low half as the multiplier shifts out
assign {mul_res_hi, mul_res_lo} = {sum_res,
                                   st_idle ? req_i.op2[MDU_XLEN-1:1] : lo_ff[MDU_XLEN-1:1]};

// --------------------
// Divide step
// --------------------

// Low dividend bits enter the partial remainder one per step
assign dvdnd_lo_next = (~is_div | st_corr) ? '0
                     : st_idle             ? req_i.op1 << 1
                                           : dvdnd_lo_ff << 1;

assign div_inv      = div_sgn & ops_diff_sgn;
assign div_step_sgn = st_corr ? (div_op1_neg ^ c_ff)
                    : st_idle ? 1'b0
                              : ~lo_ff[0];  // Previous quotient bit picks add or sub

assign div_rem_c   = sum_res[MDU_XLEN];
assign div_rem     = sum_res[MDU_XLEN-1:0];
// Zero remainder with zero dividend tail counts as equal for a negative dividend
assign div_quo_bit = ~(div_op1_neg ^ div_rem_c)
                   | (div_op1_neg & ({sum_res, dvdnd_lo_next} == '0));
assign div_quo     = st_idle ? {{(MDU_XLEN-1){1'b0}}, div_quo_bit}
                             : {lo_ff[MDU_XLEN-2:0], div_quo_bit};

// --------------------
// Shared adder
// --------------------

always_comb begin
    if (is_div) begin
        sum_sub = ~div_inv ^ div_step_sgn;
        sum_op1 = st_corr ? {1'b0, hi_ff}
                : st_idle ? {{MDU_XLEN{div_op1_neg}}, req_i.op1[MDU_XLEN-1]}
                          : {hi_ff, dvdnd_lo_ff[MDU_XLEN-1]};
        sum_op2 = {div_op2_neg, req_i.op2};
    end else begin
        sum_sub = mul_neg;
        sum_op1 = st_idle ? '0 : {mul_op1_sgn & hi_ff[MDU_XLEN-1], hi_ff};  // Accumulator
        sum_op2 = mul_add ? {mul_op1_neg, req_i.op1} : '0;                  // Partial product
    end
    sum_res = sum_sub ? (sum_op1 - sum_op2) : (sum_op1 + sum_op2);
end

// --------------------
// Registers and status
// --------------------

assign c_next  = is_div ? div_rem_c : mul_bit;  // Remainder sign or Booth history
assign hi_next = is_div ? div_rem   : mul_res_hi;
assign lo_next = is_div ? div_quo   : mul_res_lo;

always_ff @(posedge clk) begin
    if (step_en_i) begin
        c_ff        <= c_next;
        hi_ff       <= hi_next;
        lo_ff       <= lo_next;
        dvdnd_lo_ff <= dvdnd_lo_next;
    end
end

assign status_o.ops_non_zero = |req_i.op1 & |req_i.op2;
// Negate DIV quotient on mixed signs, fix REM when remainder sign is off
assign status_o.corr_req = (div_is_div & ops_diff_sgn)
                         | (div_is_rem & |div_rem & (div_op1_neg ^ div_rem_c));

always_comb begin
    case (state_i)
        MDU_ITER: res_o = is_div ? (div_is_rem ? div_rem : div_quo)
                                 : (mul_hi ? mul_res_hi : mul_res_lo);
        MDU_CORR: res_o = div_is_rem ? div_rem : -lo_ff;
        default:  res_o = ~is_div                        ? '0
                        : (|req_i.op2 | div_is_rem)      ? req_i.op1
                                                         : '1;  // Divide by zero
    endcase
end

// Registers only move on a step, across FSM and datapath
dp_hold_chk : assert property (
    @(posedge clk) disable iff (~rst_n)
    ~step_en_i |=> $stable({c_ff, hi_ff, lo_ff, dvdnd_lo_ff})
) else $error("MDU datapath: registers changed without a step");

endmodule

// File: rtl/mdu_iter_counter.sv
// One-hot step counter of the MDU, loaded at command start and shifted once per iteration
`timescale 1ns/1ps

module mdu_iter_counter import mdu_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic cnt_load_i,   // Start of an iterative command
    input  logic cnt_shift_i,  // One step done
    output logic cnt_last_o    // Final step in progress
);

logic [MDU_XLEN-2:0] cnt_ff;  // Single hot bit walks toward bit 0

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        cnt_ff <= '0;
    end else if (cnt_load_i) begin
        cnt_ff <= MDU_CNT_INIT[MDU_XLEN-2:0];
    end else if (cnt_shift_i) begin
        cnt_ff <= cnt_ff >> 1;  // Empties after the last step
    end
end

assign cnt_last_o = cnt_ff[0];

// --------------------
// Checks
// --------------------

// Shifting and loading never create a second hot bit
cnt_onehot_chk : assert property (
    @(posedge clk) disable iff (~rst_n)
    $onehot0(cnt_ff)
) else $error("MDU counter: register not one-hot");

endmodule

// File: rtl/mdu_pkg.sv
// Shared widths, enums and packed structs of the multiply/divide unit, imported by every MDU module
package mdu_pkg;

// --------------------
// Widths and constants
// --------------------

localparam int MDU_XLEN = 32;  // Data word width

// One-hot start of the step counter, 31 more steps after the first
localparam logic [MDU_XLEN-1:0] MDU_CNT_INIT = 32'b1 << (MDU_XLEN - 2);

typedef logic [MDU_XLEN-1:0] mdu_word_t;

// --------------------
// Enums
// --------------------

// Operation in funct3 order, bit 2 marks the divide class
typedef enum logic [2:0] {
    MDU_MUL    = 3'd0,
    MDU_MULH   = 3'd1,
    MDU_MULHSU = 3'd2,
    MDU_MULHU  = 3'd3,
    MDU_DIV    = 3'd4,
    MDU_DIVU   = 3'd5,
    MDU_REM    = 3'd6,
    MDU_REMU   = 3'd7
} mdu_op_e;

typedef enum logic [1:0] {
    MDU_IDLE,  // Waiting, shortcut results
    MDU_ITER,  // One step per cycle
    MDU_CORR   // Divide result fixup
} mdu_state_e;

// --------------------
// Structs
// --------------------

typedef struct packed {
    mdu_op_e   op;
    mdu_word_t op1;   // Multiplicand or dividend
    mdu_word_t op2;   // Multiplier or divisor
} mdu_req_s;

// Datapath status toward the FSM
typedef struct packed {
    logic ops_non_zero;  // Both operands non-zero
    logic corr_req;      // Divide wants the CORR cycle
} mdu_status_s;

endpackage

// File: rtl/mdu_top.sv
// Top level of the iterative multiply/divide unit, connects FSM, step counter and datapath
`timescale 1ns/1ps

module mdu_top import mdu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_vd_i,   // Held until ready
    input  mdu_req_s  req_i,
    output logic      res_rdy_o,  // Result valid pulse
    output mdu_word_t res_o
);

mdu_state_e  state;
mdu_status_s status;
logic        step_en;
logic        cnt_load;
logic        cnt_shift;
logic        cnt_last;

mdu_ctrl_fsm u_ctrl_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_vd_i    (cmd_vd_i),
    .op_i        (req_i.op),
    .status_i    (status),
    .cnt_last_i  (cnt_last),
    .state_o     (state),
    .step_en_o   (step_en),
    .cnt_load_o  (cnt_load),
    .cnt_shift_o (cnt_shift),
    .res_rdy_o   (res_rdy_o)
);

mdu_iter_counter u_iter_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .cnt_load_i  (cnt_load),
    .cnt_shift_i (cnt_shift),
    .cnt_last_o  (cnt_last)
);

mdu_datapath u_datapath (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .state_i     (state),
    .step_en_i   (step_en),
    .status_o    (status),
    .res_o       (res_o)
);

endmodule

// File: tb/mdu_stimulus.txt
// Columns: op (funct3), op1, op2, expected result, all hex
// Multiply family, every sign mix
0 00000007 00000006 0000002a
0 fffffffd 00000005 fffffff1
1 fffffffd 00000005 ffffffff
1 80000000 80000000 40000000
2 ffffffff ffffffff ffffffff
2 00000002 80000000 00000001
3 ffffffff ffffffff fffffffe
// Divide family, negative operands take the correction cycle
4 ffffffec 00000006 fffffffd
4 ffffffec fffffffa 00000003
5 ffffffec 00000006 2aaaaaa7
6 ffffffec 00000006 fffffffe
6 00000014 fffffffa 00000002
7 ffffffec 00000006 00000002
6 ffffffe8 00000006 00000000
4 ffffffe8 00000006 fffffffc
// Zero operands, divide by zero and signed overflow
4 12345678 00000000 ffffffff
6 12345678 00000000 12345678
5 0000000a 00000000 ffffffff
3 ffffffff 00000000 00000000
0 00000000 deadbeef 00000000
4 80000000 ffffffff 80000000
6 80000000 ffffffff 00000000

// File: tb/mdu_tb.sv
// MDU testbench top, runs the stimulus file and a seeded random block against a reference model
`timescale 1ns/1ps

module mdu_tb import mdu_pkg::*; ();

logic      clk;
logic      rst_n;
logic      cmd_vd;
mdu_req_s  req;
logic      res_rdy;
mdu_word_t res;
mdu_word_t vec_mem [0:255];       // Four words per vector
int        n_vec;
int        n_rand      = 48;      // Random commands after the file
int        seed        = 72906;
int        cycle_cnt   = 0;
int        cycle_limit = 100000;  // Narrowed once the vectors are counted

tb_clk_gen u_clk_gen (
    .clk_o (clk)
);

mdu_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vd_i  (cmd_vd),
    .req_i     (req),
    .res_rdy_o (res_rdy),
    .res_o     (res)
);

// --------------------
// Reference model
// --------------------

function automatic mdu_word_t model_result(mdu_op_e op, mdu_word_t a, mdu_word_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    ea = {32'b0, a};
    eb = {32'b0, b};
    if (op != MDU_MULHU)
        ea[63:32] = {32{a[31]}};  // Low product same for any extension
    if (op == MDU_MUL || op == MDU_MULH)
        eb[63:32] = {32{b[31]}};
    prod = ea * eb;
    if (!op[2])
        return (op == MDU_MUL) ? prod[31:0] : prod[63:32];
    if (b == '0)
        return op[1] ? a : '1;    // Divide by zero
    if (!op[0]) begin
        if (a == 32'h8000_0000 && b == '1)
            return op[1] ? '0 : a;  // Signed overflow
        return op[1] ? mdu_word_t'($signed(a) % $signed(b))
                     : mdu_word_t'($signed(a) / $signed(b));
    end
    return op[1] ? (a % b) : (a / b);
endfunction

// --------------------
// Checks
// --------------------

task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1);
endtask

task automatic check_res(mdu_word_t got, mdu_word_t exp);
    if (got !== exp) begin
        $display("error at %0t ns: res_o = %h, expected %h", $time, got, exp);
        abort_run();
    end
endtask

task automatic check_latency(int cycles, int bound);
    if (cycles > bound) begin
        $display("error at %0t ns: res_rdy_o after %0d cycles, bound %0d", $time, cycles, bound);
        abort_run();
    end
endtask

// One command, issued on the edge that consumes the previous result
task automatic run_cmd(mdu_op_e op, mdu_word_t a, mdu_word_t b, mdu_word_t exp);
    int lat;
    @(posedge clk);
    cmd_vd  <= 1'b1;
    req.op  <= op;
    req.op1 <= a;
    req.op2 <= b;
    lat = 0;
    do begin
        @(negedge clk);  // Outputs settled
        lat++;
    end while (!res_rdy && lat <= 33);
    check_latency(lat, (a == '0 || b == '0) ? 1 : 33);  // Shortcut in the first cycle
    check_res(res, exp);
endtask

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        abort_run();
    end
end

// --------------------
// Main sequence
// --------------------

initial begin
    int        i;
    mdu_word_t rnd;
    mdu_op_e   op;
    mdu_word_t a;
    mdu_word_t b;
    cmd_vd = 1'b0;
    req    = '0;
    rst_n  = 1'b0;
    for (i = 0; i < 256; i++)
        vec_mem[i] = 32'hdead_0000 | i;  // Op words above 7 end the list
    $readmemh("tb/mdu_stimulus.txt", vec_mem);
    n_vec = 0;
    while (n_vec < 64 && vec_mem[4*n_vec] <= 7)
        n_vec++;
    if (n_vec == 0) begin
        $display("The stimulus file tb/mdu_stimulus.txt holds no vectors");
        abort_run();
    end
    cycle_limit = (n_vec + n_rand) * 40 + 50;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) begin
        @(negedge clk);
        if (res_rdy !== 1'b0) begin
            $display("res_rdy_o is high after reset with no command");
            abort_run();
        end
    end

    // File vectors, valid held high throughout
    for (i = 0; i < n_vec; i++)
        run_cmd(mdu_op_e'(vec_mem[4*i][2:0]), vec_mem[4*i+1], vec_mem[4*i+2], vec_mem[4*i+3]);

    for (i = 0; i < n_rand; i++) begin
        rnd = $random(seed);
        op  = mdu_op_e'(rnd[2:0]);
        a   = $random(seed);
        b   = $random(seed);
        if (i % 8 == 7)
            b = b & 32'h0000_0003;  // Small divisors, zero among them
        run_cmd(op, a, b, model_result(op, a, b));
    end

    @(posedge clk);
    cmd_vd <= 1'b0;
    @(negedge clk);
    $display("=== PASS ===");
    $finish;
end

endmodule

// File: tb/tb_clk_gen.sv
// Free-running testbench clock, 4 ns period, instantiated by the MDU testbench top
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);

initial clk_o = 1'b0;

always #2 clk_o = ~clk_o;  // Half of the period

endmodule
